// File: Bender.yml
package:
  name: proc

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/proc_pkg.sv
      - rtl/fetch.sv
      - rtl/decode.sv
      - rtl/execute.sv
      - rtl/result.sv
      - rtl/hazard_detect.sv
      - rtl/proc.sv
  - target: test
    files:
      - verification/proc_properties.sv
      - verification/proc_tb.sv

// File: list.f
+incdir+rtl
rtl/proc_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/result.sv
rtl/hazard_detect.sv
rtl/proc.sv
verification/proc_properties.sv
verification/proc_tb.sv

// File: rtl/decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "proc_defs.svh"

module decode (
   input  logic                          clk,
   input  logic                          arst_n,
   input  proc_pkg::if_id_t              if_id,
   input  logic                          flush,
   input  logic                          bubble,
   input  proc_pkg::wb_t                 wb,
   output proc_pkg::id_ex_t              id_ex,
   output logic [proc_pkg::REG_AW-1:0]   rs,
   output logic [proc_pkg::REG_AW-1:0]   rt,
   output logic                          reg2_used
);

   import proc_pkg::*;

   logic [5:0]            opcode;
   logic [3:0]            funct;
   logic [REG_AW-1:0]     rd_field;
   logic [`PROC_XLEN-1:0] imm;
   logic [`PROC_XLEN-1:0] rdata_a;
   logic [`PROC_XLEN-1:0] rdata_b;
   ctrl_t                 ctrl;

   logic [`PROC_XLEN-1:0] regs [`PROC_NREGS];

   assign opcode   = if_id.instr[31:26];
   assign funct    = if_id.instr[3:0];
   assign rs       = if_id.instr[25:21];
   assign rt       = if_id.instr[20:16];
   assign rd_field = if_id.instr[15:11];
   assign imm      = {{(`PROC_XLEN-16){if_id.instr[15]}}, if_id.instr[15:0]};

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = ALU_ADD;
      ctrl.wb_sel = WB_ALU;
      reg2_used   = 1'b0;
      case (opcode)
         `PROC_OP_RTYPE: begin
            reg2_used   = 1'b1;
            ctrl.reg_wr = 1'b1;
            ctrl.rd     = rd_field;
            case (funct)
               `PROC_FN_ADD: ctrl.alu_op = ALU_ADD;
               `PROC_FN_SUB: ctrl.alu_op = ALU_SUB;
               `PROC_FN_AND: ctrl.alu_op = ALU_AND;
               `PROC_FN_OR:  ctrl.alu_op = ALU_OR;
               `PROC_FN_XOR: ctrl.alu_op = ALU_XOR;
               `PROC_FN_SLT: ctrl.alu_op = ALU_SLT;
               default:      ctrl.reg_wr = 1'b0;
            endcase
         end
         `PROC_OP_ADDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
            ctrl.rd      = rt;
         end
         `PROC_OP_LW: begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_rd  = 1'b1;
            ctrl.wb_sel  = WB_MEM;
            ctrl.reg_wr  = 1'b1;
            ctrl.rd      = rt;
         end
         `PROC_OP_SW: begin
            reg2_used    = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.mem_wr  = 1'b1;
         end
         `PROC_OP_BEQ: begin
            reg2_used      = 1'b1;
            ctrl.is_branch = 1'b1;
         end
         `PROC_OP_HALT: ctrl.is_halt = 1'b1;
         default: ;
      endcase
      // Writes to r0 are dropped so r0 is never a forwarding source
      if (ctrl.rd == '0) begin
         ctrl.reg_wr = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wb.we && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // Write-through covers the writeback in the same cycle
   assign rdata_a = (rs == '0) ? '0 :
                    (wb.we && wb.rd == rs) ? wb.data : regs[rs];
   assign rdata_b = (rt == '0) ? '0 :
                    (wb.we && wb.rd == rt) ? wb.data : regs[rt];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else if (flush || bubble) begin
         id_ex <= '0;
      end else begin
         id_ex.ctrl     <= ctrl;
         id_ex.rs       <= rs;
         id_ex.rt       <= rt;
         id_ex.op_a     <= rdata_a;
         id_ex.op_b     <= rdata_b;
         id_ex.imm      <= imm;
         id_ex.pc_plus4 <= if_id.pc_plus4;
      end
   end

endmodule

`default_nettype wire

// File: rtl/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "proc_defs.svh"

module execute (
   input  logic                  clk,
   input  logic                  arst_n,
   input  proc_pkg::id_ex_t      id_ex,
   input  proc_pkg::fwd_sel_e    fwd_a,
   input  proc_pkg::fwd_sel_e    fwd_b,
   input  logic [`PROC_XLEN-1:0] mem_fwd_data,
   input  logic [`PROC_XLEN-1:0] wb_fwd_data,
   input  logic                  flush,
   output proc_pkg::ex_mem_t     ex_mem
);

   import proc_pkg::*;

   logic [`PROC_XLEN-1:0] op_a;
   logic [`PROC_XLEN-1:0] op_b;
   logic [`PROC_XLEN-1:0] alu_b;
   logic [`PROC_XLEN-1:0] alu_res;
   logic [`PROC_XLEN-1:0] br_target;

   // Forwarding muxes
   always_comb begin
      case (fwd_a)
         FWD_MEM: op_a = mem_fwd_data;
         FWD_WB:  op_a = wb_fwd_data;
         default: op_a = id_ex.op_a;
      endcase
      case (fwd_b)
         FWD_MEM: op_b = mem_fwd_data;
         FWD_WB:  op_b = wb_fwd_data;
         default: op_b = id_ex.op_b;
      endcase
   end

   assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         ALU_SUB: alu_res = op_a - alu_b;
         ALU_AND: alu_res = op_a & alu_b;
         ALU_OR:  alu_res = op_a | alu_b;
         ALU_XOR: alu_res = op_a ^ alu_b;
         ALU_SLT: alu_res = {{(`PROC_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
         default: alu_res = op_a + alu_b;
      endcase
   end

   // Word offset relative to the next instruction
   assign br_target = id_ex.pc_plus4 + {id_ex.imm[`PROC_XLEN-3:0], 2'b00};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else begin
         ex_mem.ctrl       <= flush ? '0 : id_ex.ctrl;
         ex_mem.alu_res    <= alu_res;
         ex_mem.store_data <= op_b;
         ex_mem.br_target  <= br_target;
         ex_mem.equal      <= (op_a == op_b);
      end
   end

endmodule

`default_nettype wire

// File: rtl/fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "proc_defs.svh"

module fetch (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  stall,
   input  logic                  take_branch,
   input  logic [`PROC_XLEN-1:0] branch_target,
   input  logic [`PROC_XLEN-1:0] instr,
   output logic [`PROC_XLEN-1:0] instr_addr,
   output proc_pkg::if_id_t      if_id
);

   logic [`PROC_XLEN-1:0] pc_q;
   logic [`PROC_XLEN-1:0] pc_plus4;
   logic                  freeze_q;
   logic                  fetch_halt;

   assign pc_plus4   = pc_q + `PROC_XLEN'd4;
   assign fetch_halt = (instr[31:26] == `PROC_OP_HALT);
   assign instr_addr = pc_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q     <= '0;
         freeze_q <= 1'b0;
         if_id    <= '0;
      end else if (take_branch) begin
         // Redirect also releases a halt fetched in the branch shadow
         pc_q     <= branch_target;
         freeze_q <= 1'b0;
         if_id    <= '0;
      end else if (!stall) begin
         if (freeze_q) begin
            if_id <= '0;
         end else begin
            // PC parks on the halt
            pc_q           <= fetch_halt ? pc_q : pc_plus4;
            freeze_q       <= fetch_halt;
            if_id.instr    <= instr;
            if_id.pc_plus4 <= pc_plus4;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/hazard_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detect (
   input  logic [proc_pkg::REG_AW-1:0] id_rs,
   input  logic [proc_pkg::REG_AW-1:0] id_rt,
   input  logic                        id_reg2_used,
   input  proc_pkg::id_ex_t            id_ex,
   input  proc_pkg::ex_mem_t           ex_mem,
   input  proc_pkg::wb_t               wb,
   output logic                        stall,
   output proc_pkg::fwd_sel_e          fwd_a,
   output proc_pkg::fwd_sel_e          fwd_b
);

   import proc_pkg::*;

   // Memory stage wins over writeback and r0 never forwards
   function automatic fwd_sel_e pick_src(input logic [REG_AW-1:0] src);
      if (ex_mem.ctrl.reg_wr && ex_mem.ctrl.rd != '0 && ex_mem.ctrl.rd == src) begin
         return FWD_MEM;
      end else if (wb.we && wb.rd != '0 && wb.rd == src) begin
         return FWD_WB;
      end
      return FWD_REG;
   endfunction

   // Load in execute feeding the instruction in decode
   assign stall = id_ex.ctrl.mem_rd && id_ex.ctrl.rd != '0 &&
                  (id_ex.ctrl.rd == id_rs || (id_reg2_used && id_ex.ctrl.rd == id_rt));

   always_comb begin
      fwd_a = pick_src(id_ex.rs);
      fwd_b = pick_src(id_ex.rt);
   end

endmodule

`default_nettype wire

// File: rtl/proc.sv
`timescale 1ns/1ps
`default_nettype none

`include "proc_defs.svh"

module proc (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [`PROC_XLEN-1:0] instr,
   input  logic [`PROC_XLEN-1:0] data_rdata,
   output logic [`PROC_XLEN-1:0] instr_addr,
   output proc_pkg::mem_req_t    data_req,
   output logic                  halted
);

   import proc_pkg::*;

   if_id_t                if_id;
   id_ex_t                id_ex;
   ex_mem_t               ex_mem;
   wb_t                   wb;
   logic                  stall;
   logic                  take_branch;
   logic [`PROC_XLEN-1:0] branch_target;
   logic [REG_AW-1:0]     id_rs;
   logic [REG_AW-1:0]     id_rt;
   logic                  id_reg2_used;
   fwd_sel_e              fwd_a;
   fwd_sel_e              fwd_b;

   fetch u_fetch (
      .clk           (clk),
      .arst_n        (arst_n),
      .stall         (stall),
      .take_branch   (take_branch),
      .branch_target (branch_target),
      .instr         (instr),
      .instr_addr    (instr_addr),
      .if_id         (if_id)
   );

   // Stall turns the decode slot into a bubble while fetch holds
   decode u_decode (
      .clk       (clk),
      .arst_n    (arst_n),
      .if_id     (if_id),
      .flush     (take_branch),
      .bubble    (stall),
      .wb        (wb),
      .id_ex     (id_ex),
      .rs        (id_rs),
      .rt        (id_rt),
      .reg2_used (id_reg2_used)
   );

   execute u_execute (
      .clk          (clk),
      .arst_n       (arst_n),
      .id_ex        (id_ex),
      .fwd_a        (fwd_a),
      .fwd_b        (fwd_b),
      .mem_fwd_data (ex_mem.alu_res),
      .wb_fwd_data  (wb.data),
      .flush        (take_branch),
      .ex_mem       (ex_mem)
   );

   result u_result (
      .clk           (clk),
      .arst_n        (arst_n),
      .ex_mem        (ex_mem),
      .data_rdata    (data_rdata),
      .data_req      (data_req),
      .take_branch   (take_branch),
      .branch_target (branch_target),
      .wb            (wb),
      .halted        (halted)
   );

   hazard_detect u_hazard_detect (
      .id_rs        (id_rs),
      .id_rt        (id_rt),
      .id_reg2_used (id_reg2_used),
      .id_ex        (id_ex),
      .ex_mem       (ex_mem),
      .wb           (wb),
      .stall        (stall),
      .fwd_a        (fwd_a),
      .fwd_b        (fwd_b)
   );

endmodule

`default_nettype wire

// File: rtl/proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Data and address width
`define PROC_XLEN 32
`define PROC_NREGS 32

// Opcodes in bits 31:26
`define PROC_OP_RTYPE 6'h00
`define PROC_OP_ADDI 6'h08
`define PROC_OP_LW 6'h23
`define PROC_OP_SW 6'h2b
`define PROC_OP_BEQ 6'h04
`define PROC_OP_HALT 6'h3f

// R-type functions in bits 3:0
`define PROC_FN_ADD 4'h0
`define PROC_FN_SUB 4'h2
`define PROC_FN_AND 4'h4
`define PROC_FN_OR 4'h5
`define PROC_FN_XOR 4'h6
`define PROC_FN_SLT 4'ha

`endif

// File: rtl/proc_pkg.sv
`default_nettype none

`include "proc_defs.svh"

package proc_pkg;

   localparam int unsigned REG_AW = $clog2(`PROC_NREGS);

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } alu_op_e;

   typedef enum logic {
      WB_ALU,
      WB_MEM
   } wb_sel_e;

   // Operand source for execute
   typedef enum logic [1:0] {
      FWD_REG,
      FWD_MEM,
      FWD_WB
   } fwd_sel_e;

   typedef struct packed {
      alu_op_e           alu_op;
      logic              use_imm;
      logic              mem_rd;
      logic              mem_wr;
      logic              is_branch;
      logic              is_halt;
      wb_sel_e           wb_sel;
      logic              reg_wr;
      logic [REG_AW-1:0] rd;
   } ctrl_t;

   typedef struct packed {
      logic [`PROC_XLEN-1:0] instr;
      logic [`PROC_XLEN-1:0] pc_plus4;
   } if_id_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [REG_AW-1:0]     rs;
      logic [REG_AW-1:0]     rt;
      logic [`PROC_XLEN-1:0] op_a;
      logic [`PROC_XLEN-1:0] op_b;
      logic [`PROC_XLEN-1:0] imm;
      logic [`PROC_XLEN-1:0] pc_plus4;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [`PROC_XLEN-1:0] alu_res;
      logic [`PROC_XLEN-1:0] store_data;
      logic [`PROC_XLEN-1:0] br_target;
      logic                  equal;
   } ex_mem_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [`PROC_XLEN-1:0] alu_res;
      logic [`PROC_XLEN-1:0] load_data;
   } mem_wb_t;

   // Register file write port
   typedef struct packed {
      logic                  we;
      logic [REG_AW-1:0]     rd;
      logic [`PROC_XLEN-1:0] data;
   } wb_t;

   typedef struct packed {
      logic                  en;
      logic                  wr;
      logic [`PROC_XLEN-1:0] addr;
      logic [`PROC_XLEN-1:0] wdata;
   } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/result.sv
`timescale 1ns/1ps
`default_nettype none

`include "proc_defs.svh"

module result (
   input  logic                  clk,
   input  logic                  arst_n,
   input  proc_pkg::ex_mem_t     ex_mem,
   input  logic [`PROC_XLEN-1:0] data_rdata,
   output proc_pkg::mem_req_t    data_req,
   output logic                  take_branch,
   output logic [`PROC_XLEN-1:0] branch_target,
   output proc_pkg::wb_t         wb,
   output logic                  halted
);

   import proc_pkg::*;

   mem_wb_t mem_wb_q;
   logic    halt_seen_q;

   // Single-cycle data memory, address from the ALU
   always_comb begin
      data_req.en    = ex_mem.ctrl.mem_rd | ex_mem.ctrl.mem_wr;
      data_req.wr    = ex_mem.ctrl.mem_wr;
      data_req.addr  = ex_mem.alu_res;
      data_req.wdata = ex_mem.store_data;
   end

   // beq resolves here
   assign take_branch   = ex_mem.ctrl.is_branch & ex_mem.equal;
   assign branch_target = ex_mem.br_target;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_wb_q <= '0;
      end else begin
         mem_wb_q.ctrl      <= ex_mem.ctrl;
         mem_wb_q.alu_res   <= ex_mem.alu_res;
         mem_wb_q.load_data <= data_rdata;
      end
   end

   always_comb begin
      wb.we   = mem_wb_q.ctrl.reg_wr;
      wb.rd   = mem_wb_q.ctrl.rd;
      wb.data = (mem_wb_q.ctrl.wb_sel == WB_MEM) ? mem_wb_q.load_data : mem_wb_q.alu_res;
   end

   // Sticky once the halt is in writeback
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_seen_q <= 1'b0;
      end else if (mem_wb_q.ctrl.is_halt) begin
         halt_seen_q <= 1'b1;
      end
   end

   assign halted = halt_seen_q | mem_wb_q.ctrl.is_halt;

endmodule

`default_nettype wire

// File: verification/proc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module proc_properties (
   input logic               clk,
   input logic               arst_n,
   input proc_pkg::mem_req_t data_req,
   input logic               halted
);

   int unsigned assert_failures = 0;

   // A write never goes out without an enable
   wr_implies_en: assert property (@(posedge clk) disable iff (!arst_n)
      data_req.wr |-> data_req.en)
      else begin
         assert_failures++;
         $error("data_req.wr asserted without data_req.en");
      end

   // halted is sticky until reset
   halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
      halted |=> halted)
      else begin
         assert_failures++;
         $error("halted fell without a reset");
      end

   // Nothing behind a halt reaches memory
   no_store_halted: assert property (@(posedge clk) disable iff (!arst_n)
      halted |-> !data_req.wr)
      else begin
         assert_failures++;
         $error("store issued while halted");
      end

endmodule

bind proc proc_properties u_proc_properties (
   .clk      (clk),
   .arst_n   (arst_n),
   .data_req (data_req),
   .halted   (halted)
);

`default_nettype wire

// File: verification/proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "proc_defs.svh"

module proc_tb;

   import proc_pkg::*;

   localparam int MEM_WORDS = 256;

   logic                  clk;
   logic                  arst_n;
   logic [`PROC_XLEN-1:0] instr;
   logic [`PROC_XLEN-1:0] data_rdata;
   logic [`PROC_XLEN-1:0] instr_addr;
   mem_req_t              data_req;
   logic                  halted;

   logic [`PROC_XLEN-1:0] imem [MEM_WORDS];
   logic [`PROC_XLEN-1:0] dmem [MEM_WORDS];

   // Test table, flattened into shared queues
   string                 names[$];
   int                    prog_base[$];
   int                    prog_len[$];
   int                    store_base[$];
   int                    store_num[$];
   logic [`PROC_XLEN-1:0] halt_pc[$];
   logic [`PROC_XLEN-1:0] prog[$];
   mem_req_t              want[$];
   mem_req_t              seen[$];

   int                    cur_base;
   int                    cur_store_base;
   logic [`PROC_XLEN-1:0] cur_halt_pc;

   integer                seed = 32'h3c002c6b;
   int                    errors;
   int                    passed;
   int                    failed;
   int                    watchdog_cycles = 0;

   proc u_proc (
      .clk        (clk),
      .arst_n     (arst_n),
      .instr      (instr),
      .data_rdata (data_rdata),
      .instr_addr (instr_addr),
      .data_req   (data_req),
      .halted     (halted)
   );

   always #5 clk = ~clk;

   // Single-cycle memories
   assign instr      = imem[instr_addr[9:2]];
   assign data_rdata = dmem[data_req.addr[9:2]];

   always @(posedge clk) begin
      if (arst_n && data_req.en && data_req.wr) begin
         dmem[data_req.addr[9:2]] <= data_req.wdata;
         seen.push_back(data_req);
      end
   end

   function automatic logic [31:0] rtype_word(input logic [3:0] fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt);
      return {`PROC_OP_RTYPE, rs, rt, rd, 7'd0, fn};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] halt_word();
      return {`PROC_OP_HALT, 26'd0};
   endfunction

   function automatic logic [31:0] sext16(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic logic [31:0] apply_op(input logic [3:0] fn, input logic [31:0] x,
                                            input logic [31:0] y);
      case (fn)
         `PROC_FN_ADD: return x + y;
         `PROC_FN_SUB: return x - y;
         `PROC_FN_AND: return x & y;
         `PROC_FN_OR:  return x | y;
         `PROC_FN_XOR: return x ^ y;
         `PROC_FN_SLT: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         default:      return '0;
      endcase
   endfunction

   // Background data, different at every word
   function automatic logic [31:0] dmem_fill(input int i);
      return 32'h9e3779b9 * (i + 1);
   endfunction

   task automatic open_test(input string name);
      names.push_back(name);
      cur_base       = prog.size();
      cur_store_base = want.size();
   endtask

   task automatic emit(input logic [31:0] word);
      prog.push_back(word);
   endtask

   task automatic emit_halt();
      cur_halt_pc = (prog.size() - cur_base) * 4;
      prog.push_back(halt_word());
   endtask

   task automatic want_store(input logic [31:0] addr, input logic [31:0] data);
      mem_req_t r;
      r.en    = 1'b1;
      r.wr    = 1'b1;
      r.addr  = addr;
      r.wdata = data;
      want.push_back(r);
   endtask

   task automatic close_test();
      prog_base.push_back(cur_base);
      prog_len.push_back(prog.size() - cur_base);
      store_base.push_back(cur_store_base);
      store_num.push_back(want.size() - cur_store_base);
      halt_pc.push_back(cur_halt_pc);
   endtask

   task automatic build_table();
      logic [3:0]  fns [6];
      logic [31:0] rnd;
      logic [15:0] ia;
      logic [15:0] ib;
      logic [15:0] off;
      logic [31:0] x1;
      logic [31:0] x2;
      logic [31:0] x3;
      logic [31:0] x4;
      logic [31:0] x5;
      fns = '{`PROC_FN_ADD, `PROC_FN_SUB, `PROC_FN_AND, `PROC_FN_OR, `PROC_FN_XOR, `PROC_FN_SLT};

      // Negative a against positive b so signed slt differs from unsigned
      rnd = $random(seed);
      ia  = rnd[15:0] | 16'h8000;
      rnd = $random(seed);
      ib  = rnd[15:0] & 16'h7fff;
      x1  = sext16(ia);
      x2  = sext16(ib);
      off = 16'h0100;
      open_test("alu");
      emit(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, ia));
      emit(itype_word(`PROC_OP_ADDI, 5'd2, 5'd0, ib));
      for (int k = 0; k < 6; k++) begin
         emit(rtype_word(fns[k], 5'd3, 5'd1, 5'd2));
         emit(itype_word(`PROC_OP_SW, 5'd3, 5'd0, off));
         want_store(sext16(off), apply_op(fns[k], x1, x2));
         off = off + 16'd4;
      end
      emit(rtype_word(`PROC_FN_SLT, 5'd3, 5'd2, 5'd1));
      emit(itype_word(`PROC_OP_SW, 5'd3, 5'd0, off));
      want_store(sext16(off), apply_op(`PROC_FN_SLT, x2, x1));
      emit_halt();
      close_test();

      // Dependencies at distances one, two and three
      rnd = $random(seed);
      ia  = rnd[15:0];
      x1  = sext16(ia);
      x2  = x1 + x1;
      x3  = x2 - x1;
      x4  = x3 ^ x1;
      x5  = x2 + x4;
      open_test("forwarding");
      emit(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, ia));
      emit(rtype_word(`PROC_FN_ADD, 5'd2, 5'd1, 5'd1));
      emit(rtype_word(`PROC_FN_SUB, 5'd3, 5'd2, 5'd1));
      emit(rtype_word(`PROC_FN_XOR, 5'd4, 5'd3, 5'd1));
      emit(rtype_word(`PROC_FN_ADD, 5'd5, 5'd2, 5'd4));
      emit(itype_word(`PROC_OP_SW, 5'd5, 5'd0, 16'h0180));
      emit(itype_word(`PROC_OP_SW, 5'd3, 5'd0, 16'h0184));
      emit(itype_word(`PROC_OP_SW, 5'd2, 5'd0, 16'h0188));
      want_store(32'h180, x5);
      want_store(32'h184, x3);
      want_store(32'h188, x2);
      emit_halt();
      close_test();

      rnd = $random(seed);
      ia  = rnd[15:0];
      x1  = sext16(ia);
      open_test("load_use");
      emit(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, ia));
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h0200));
      emit(itype_word(`PROC_OP_LW, 5'd2, 5'd0, 16'h0200));
      emit(rtype_word(`PROC_FN_ADD, 5'd3, 5'd2, 5'd1));
      emit(itype_word(`PROC_OP_SW, 5'd3, 5'd0, 16'h0204));
      emit(itype_word(`PROC_OP_ADDI, 5'd0, 5'd0, 16'h0005));
      emit(itype_word(`PROC_OP_SW, 5'd0, 5'd0, 16'h0208));
      emit(itype_word(`PROC_OP_LW, 5'd5, 5'd0, 16'h0204));
      emit(itype_word(`PROC_OP_SW, 5'd5, 5'd0, 16'h020c));
      want_store(32'h200, x1);
      want_store(32'h204, x1 + x1);
      want_store(32'h208, 32'd0);
      want_store(32'h20c, x1 + x1);
      emit_halt();
      close_test();

      // Not-taken beq, then a taken one over three stores
      rnd = $random(seed);
      ia  = rnd[15:0];
      ib  = ia ^ 16'h0001;
      x1  = sext16(ia);
      x3  = sext16(ib);
      open_test("branch");
      emit(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, ia));
      emit(itype_word(`PROC_OP_ADDI, 5'd2, 5'd0, ia));
      emit(itype_word(`PROC_OP_ADDI, 5'd3, 5'd0, ib));
      emit(itype_word(`PROC_OP_BEQ, 5'd3, 5'd1, 16'd1));
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h0280));
      emit(itype_word(`PROC_OP_BEQ, 5'd2, 5'd1, 16'd3));
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h0284));
      emit(itype_word(`PROC_OP_SW, 5'd2, 5'd0, 16'h0288));
      emit(itype_word(`PROC_OP_SW, 5'd3, 5'd0, 16'h028c));
      emit(itype_word(`PROC_OP_SW, 5'd3, 5'd0, 16'h0290));
      want_store(32'h280, x1);
      want_store(32'h290, x3);
      emit_halt();
      close_test();

      // Halt in the branch shadow, store after the real halt
      rnd = $random(seed);
      ia  = rnd[15:0];
      x1  = sext16(ia);
      open_test("halt");
      emit(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, ia));
      emit(itype_word(`PROC_OP_BEQ, 5'd0, 5'd0, 16'd3));
      emit(halt_word());
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h0300));
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h0304));
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h0308));
      emit_halt();
      emit(itype_word(`PROC_OP_SW, 5'd1, 5'd0, 16'h030c));
      want_store(32'h308, x1);
      close_test();
   endtask

   task automatic check_store(input string name, input int idx, input mem_req_t exp,
                              input mem_req_t act);
      if (act !== exp) begin
         $display("Mismatch in %s store %0d: expected addr %h data %h, actual addr %h data %h",
                  name, idx, exp.addr, exp.wdata, act.addr, act.wdata);
         errors++;
      end
   endtask

   task automatic check_halt(input string name, input logic [`PROC_XLEN-1:0] exp,
                             input logic [`PROC_XLEN-1:0] act);
      if (act !== exp) begin
         $display("Mismatch in %s halt PC: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic run_test(input int t);
      int errs_before;
      int cycles;
      int limit;
      int n;
      errs_before = errors;
      limit       = prog_len[t] * 10;
      @(posedge clk);
      arst_n <= 1'b0;
      @(negedge clk);
      for (int i = 0; i < MEM_WORDS; i++) begin
         imem[i] = '0;
         dmem[i] = dmem_fill(i);
      end
      for (int i = 0; i < prog_len[t]; i++) begin
         imem[i] = prog[prog_base[t] + i];
      end
      seen.delete();
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;

      cycles = 0;
      @(negedge clk);
      while (halted !== 1'b1 && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1) begin
         $display("%s: core did not halt within %0d cycles", names[t], limit);
         errors++;
      end else begin
         check_halt(names[t], halt_pc[t], instr_addr);
         // Give any store behind the halt time to show up
         repeat (5) @(negedge clk);
      end

      if (seen.size() != store_num[t]) begin
         $display("%s: expected %0d stores but saw %0d", names[t], store_num[t], seen.size());
         errors++;
      end
      n = (seen.size() < store_num[t]) ? seen.size() : store_num[t];
      for (int i = 0; i < n; i++) begin
         check_store(names[t], i, want[store_base[t] + i], seen[i]);
      end

      if (errors == errs_before) begin
         passed++;
         $display("PASS %s", names[t]);
      end else begin
         failed++;
         $display("FAIL %s with %0d errors", names[t], errors - errs_before);
      end
   endtask

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles", watchdog_cycles);
      $display("Verification failed");
      $finish;
   end

   initial begin
      int total;
      int asserts;
      clk    = 1'b0;
      arst_n = 1'b0;
      errors = 0;
      passed = 0;
      failed = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         imem[i] = '0;
         dmem[i] = dmem_fill(i);
      end
      build_table();
      total = 0;
      for (int t = 0; t < prog_len.size(); t++) begin
         total += prog_len[t];
      end
      watchdog_cycles = total * 20;

      for (int t = 0; t < names.size(); t++) begin
         run_test(t);
      end

      asserts = u_proc.u_proc_properties.assert_failures;
      $display("Tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
               passed, failed, errors, asserts);
      if (errors == 0 && failed == 0 && asserts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
